/* include/fc_defs.svh */
`ifndef FC_DEFS_SVH
`define FC_DEFS_SVH

//////////////////////////////
// frame geometry
//////////////////////////////

// features per frame, one per valid beat
`define FC_IN 16
// output channels, one score per class
`define FC_CO 3

//////////////////////////////
// data widths
//////////////////////////////

// signed input feature
`define FEAT_BW 8
// signed weight
`define W_BW 8
// running sum per channel, 16 products of 8x8 fit with room
`define ST3_ACC_BW 20
// signed bias word from the bias memory
`define ST3_BIAS_BW 16
// score is sum plus bias, one bit wider than the sum
`define ST3_OUT_BW 21
// beat counter inside a frame
`define IDX_BW 4
// class index
`define CLASS_BW 2

`endif

/* rtl/fc_pkg.sv */
`default_nettype none

`include "fc_defs.svh"

package fc_pkg;

    //////////////////////////////
    // datapath word types
    //////////////////////////////

    typedef logic signed [`FEAT_BW-1:0]     feat_t;
    typedef logic signed [`W_BW-1:0]        weight_t;
    typedef logic signed [`ST3_ACC_BW-1:0]  acc_t;
    typedef logic signed [`ST3_BIAS_BW-1:0] bias_t;
    // channel sum plus bias
    typedef logic signed [`ST3_OUT_BW-1:0]  score_t;
    // winning channel
    typedef logic [`CLASS_BW-1:0]           class_t;

    // mac array frame state
    typedef enum logic {
        IDLE,
        ACCUM
    } acc_state_t;

endpackage

`default_nettype wire

/* rtl/fc_mac_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_defs.svh"

module fc_mac_array import fc_pkg::*; (
    input  wire                     clk,
    input  wire                     reset_n,

    // pooled feature stream, no ready
    input  wire                     i_feat_valid,
    input  wire feat_t              i_feat,

    // one-cycle pulse per finished frame
    output logic                    o_acc_valid,
    output acc_t [`FC_CO-1:0]       o_acc_sum
);

    // one weight per feature per channel
    localparam int W_DEPTH = `FC_IN * `FC_CO;

    //////////////////////////////
    // weight rom
    //////////////////////////////

    // layout is feature * FC_CO + channel
    weight_t weight_mem [W_DEPTH];

    initial begin
        $readmemh("stage3_fc1_weight.mem", weight_mem);
    end

    //////////////////////////////
    // frame control
    //////////////////////////////

    acc_state_t              state;
    logic [`IDX_BW-1:0]      beat_cnt;
    logic                    last_beat;

    // beat count 15 closes the frame
    assign last_beat = (beat_cnt == `IDX_BW'(`FC_IN - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= IDLE;
            beat_cnt    <= '0;
            o_acc_valid <= 1'b0;
        end else begin
            // pulse only
            o_acc_valid <= 1'b0;
            if (i_feat_valid) begin
                if (last_beat) begin
                    state       <= IDLE;
                    beat_cnt    <= '0;
                    o_acc_valid <= 1'b1;
                end else begin
                    state    <= ACCUM;
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // multiply accumulate
    //////////////////////////////

    // full 16-bit signed product per channel
    logic signed [`FEAT_BW+`W_BW-1:0] prod     [`FC_CO];
    acc_t                             acc      [`FC_CO];
    acc_t                             acc_next [`FC_CO];

    always_comb begin
        for (int ch = 0; ch < `FC_CO; ch++) begin
            prod[ch] = i_feat * weight_mem[int'(beat_cnt) * `FC_CO + ch];
            // first beat of a frame starts a fresh sum
            if (state == IDLE) begin
                acc_next[ch] = acc_t'(prod[ch]);
            end else begin
                // product sign extends to the accumulator width
                acc_next[ch] = acc[ch] + prod[ch];
            end
        end
    end

    // running sums, reloaded on every first beat
    always_ff @(posedge clk) begin
        if (i_feat_valid) begin
            for (int ch = 0; ch < `FC_CO; ch++) begin
                acc[ch] <= acc_next[ch];
            end
        end
    end

    // finished sums include the last product
    always_ff @(posedge clk) begin
        if (i_feat_valid && last_beat) begin
            for (int ch = 0; ch < `FC_CO; ch++) begin
                o_acc_sum[ch] <= acc_next[ch];
            end
        end
    end

    // frames are at least 16 beats apart so the pulse never repeats
    a_acc_valid_pulse: assert property (
        @(posedge clk) disable iff (!reset_n)
        o_acc_valid |=> !o_acc_valid
    );

endmodule

`default_nettype wire

/* rtl/fc_bias_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_defs.svh"

module fc_bias_core import fc_pkg::*; (
    input  wire                     clk,
    input  wire                     reset_n,

    // finished channel sums from the mac array
    input  wire                     i_in_valid,
    input  wire acc_t [`FC_CO-1:0]  i_in_acc,

    // scores, one cycle behind the sums
    output logic                    o_ot_valid,
    output score_t [`FC_CO-1:0]     o_ot_result
);

    //////////////////////////////
    // bias rom
    //////////////////////////////

    bias_t bias_mem [`FC_CO];

    initial begin
        $readmemh("stage3_fc1_bias.mem", bias_mem);
    end

    // sum plus bias, both sign extended to score width
    score_t biased [`FC_CO];

    always_comb begin
        for (int ch = 0; ch < `FC_CO; ch++) begin
            biased[ch] = score_t'($signed(i_in_acc[ch])) + score_t'(bias_mem[ch]);
        end
    end

    //////////////////////////////
    // output registers
    //////////////////////////////

    // result holds between frames
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_result <= '0;
        end else if (i_in_valid) begin
            for (int ch = 0; ch < `FC_CO; ch++) begin
                o_ot_result[ch] <= biased[ch];
            end
        end
    end

    // fixed latency of one
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
        end else begin
            o_ot_valid <= i_in_valid;
        end
    end

    a_valid_delay: assert property (
        @(posedge clk) disable iff (!reset_n)
        o_ot_valid == $past(i_in_valid)
    );

endmodule

`default_nettype wire

/* rtl/fc_argmax.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_defs.svh"

module fc_argmax import fc_pkg::*; (
    input  wire                      clk,
    input  wire                      reset_n,

    input  wire                      i_score_valid,
    input  wire score_t [`FC_CO-1:0] i_score,

    // decision plus the scores that produced it
    output logic                     o_class_valid,
    output class_t                   o_class,
    output score_t [`FC_CO-1:0]      o_scores
);

    class_t best_idx;
    score_t best_val;

    // strict greater than, so the lowest index keeps a tie
    always_comb begin
        best_idx = '0;
        best_val = $signed(i_score[0]);
        for (int ch = 1; ch < `FC_CO; ch++) begin
            if ($signed(i_score[ch]) > best_val) begin
                best_val = $signed(i_score[ch]);
                best_idx = class_t'(ch);
            end
        end
    end

    //////////////////////////////
    // result registers
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_class_valid <= 1'b0;
            o_class       <= '0;
            o_scores      <= '0;
        end else begin
            o_class_valid <= i_score_valid;
            // hold last decision between frames
            if (i_score_valid) begin
                o_class  <= best_idx;
                o_scores <= i_score;
            end
        end
    end

    a_class_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        o_class_valid |-> (o_class < `FC_CO)
    );

endmodule

`default_nettype wire

/* rtl/fc_stage3_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_defs.svh"

module fc_stage3_top import fc_pkg::*; (
    input  wire                  clk,
    input  wire                  reset_n,

    // pooled feature stream
    input  wire                  i_feat_valid,
    input  wire feat_t           i_feat,

    // class decision, three edges after the last beat
    output logic                 o_class_valid,
    output class_t               o_class,
    output score_t [`FC_CO-1:0]  o_scores
);

    //////////////////////////////
    // stage links
    //////////////////////////////

    // mac array to bias core
    logic                  acc_valid;
    acc_t [`FC_CO-1:0]     acc_sum;

    // bias core to argmax
    logic                  score_valid;
    score_t [`FC_CO-1:0]   score;

    // per-frame channel sums
    fc_mac_array u_mac_array (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_feat_valid (i_feat_valid),
        .i_feat       (i_feat),
        .o_acc_valid  (acc_valid),
        .o_acc_sum    (acc_sum)
    );

    // bias add and score register
    fc_bias_core u_bias_core (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (acc_valid),
        .i_in_acc    (acc_sum),
        .o_ot_valid  (score_valid),
        .o_ot_result (score)
    );

    // winning class
    fc_argmax u_argmax (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_score_valid (score_valid),
        .i_score       (score),
        .o_class_valid (o_class_valid),
        .o_class       (o_class),
        .o_scores      (o_scores)
    );

endmodule

`default_nettype wire

/* testbench/tb_fc_stage3.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_defs.svh"

module tb_fc_stage3 import fc_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int MAX_GAP    = 3;
    // partial + 40 random + 8 back to back + 3 fixed + 1 after reset
    localparam int NUM_FRAMES = 53;
    localparam int TIMEOUT_NS = (NUM_FRAMES * `FC_IN * (MAX_GAP + 1) + 200) * CLK_PERIOD;

    // frame content modes
    localparam int FRAME_RAND = 0;
    localparam int FRAME_ZERO = 1;
    localparam int FRAME_MIN  = 2;
    localparam int FRAME_MAX  = 3;

    logic                clk;
    logic                reset_n;
    logic                i_feat_valid;
    feat_t               i_feat;
    logic                o_class_valid;
    class_t              o_class;
    score_t [`FC_CO-1:0] o_scores;

    // model tables, loaded from the same memory files
    logic signed [`W_BW-1:0]        w_ref [`FC_IN * `FC_CO];
    logic signed [`ST3_BIAS_BW-1:0] b_ref [`FC_CO];

    // expected results in frame order, three scores per frame
    int q_cyc [$];
    int q_cls [$];
    int q_score [$];

    int          cyc;
    int          errors;
    int          checks;
    logic [31:0] rng;

    fc_stage3_top DUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_feat_valid  (i_feat_valid),
        .i_feat        (i_feat),
        .o_class_valid (o_class_valid),
        .o_class       (o_class),
        .o_scores      (o_scores)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // edge counter for latency checks
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // xorshift32 step
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic apply_reset();
        reset_n      = 1'b0;
        i_feat_valid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        i_feat_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    // wait until every queued frame has come out
    task automatic drain_results();
        i_feat_valid = 1'b0;
        while (q_cyc.size() != 0) @(posedge clk);
        #1;
    endtask

    // build one frame, model it, then drive the beats
    task automatic run_frame(input int mode, input int max_gap, input int beats);
        feat_t feats [`FC_IN];
        int    sum [`FC_CO];
        int    best;
        int    gap;
        for (int b = 0; b < `FC_IN; b++) begin
            rng = next_random(rng);
            case (mode)
                FRAME_ZERO: feats[b] = '0;
                FRAME_MIN:  feats[b] = feat_t'(8'h80);
                FRAME_MAX:  feats[b] = feat_t'(8'h7f);
                default:    feats[b] = feat_t'(rng[7:0]);
            endcase
        end
        // score = bias + sum of feature * weight
        for (int ch = 0; ch < `FC_CO; ch++) begin
            sum[ch] = int'(b_ref[ch]);
            for (int b = 0; b < `FC_IN; b++) begin
                sum[ch] += int'(feats[b]) * int'(w_ref[b * `FC_CO + ch]);
            end
        end
        // lowest index keeps a tie
        best = 0;
        for (int ch = 1; ch < `FC_CO; ch++) begin
            if (sum[ch] > sum[best]) begin
                best = ch;
            end
        end
        for (int b = 0; b < beats; b++) begin
            rng = next_random(rng);
            gap = (max_gap == 0) ? 0 : int'(rng[7:0]) % (max_gap + 1);
            repeat (gap) begin
                // garbage on the bus while idle
                i_feat_valid = 1'b0;
                i_feat       = feat_t'(rng[15:8]);
                @(posedge clk);
                #1;
            end
            i_feat_valid = 1'b1;
            i_feat       = feats[b];
            // accepted at next edge, visible after two more
            if (b == `FC_IN - 1) begin
                q_cyc.push_back(cyc + 3);
                q_cls.push_back(best);
                for (int ch = 0; ch < `FC_CO; ch++) begin
                    q_score.push_back(sum[ch]);
                end
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_result();
        int exp_cyc;
        int exp_cls;
        int exp_s;
        exp_cyc = q_cyc.pop_front();
        exp_cls = q_cls.pop_front();
        checks++;
        if (exp_cyc != cyc) begin
            errors++;
            $display("[ERROR] %0t: result in cycle %0d, expected %0d", $time, cyc, exp_cyc);
        end
        for (int ch = 0; ch < `FC_CO; ch++) begin
            exp_s = q_score.pop_front();
            if (int'(o_scores[ch]) != exp_s) begin
                errors++;
                $display("[ERROR] %0t: score %0d is %0d, expected %0d",
                         $time, ch, int'(o_scores[ch]), exp_s);
            end
        end
        if (int'(o_class) != exp_cls) begin
            errors++;
            $display("[ERROR] %0t: class %0d, expected %0d", $time, o_class, exp_cls);
        end
    endtask

    //////////////////////////////
    // output monitor
    //////////////////////////////

    // sample mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!reset_n) begin
            checks++;
            if (o_class_valid !== 1'b0 || o_scores !== '0) begin
                errors++;
                $display("[ERROR] %0t: outputs not cleared during reset", $time);
            end
        end else if (o_class_valid === 1'b1) begin
            if (q_cyc.size() == 0) begin
                errors++;
                $display("[ERROR] %0t: unexpected o_class_valid", $time);
            end else begin
                check_result();
            end
        end else if (q_cyc.size() != 0 && q_cyc[0] <= cyc) begin
            errors++;
            $display("[ERROR] %0t: no result for frame due in cycle %0d", $time, q_cyc[0]);
            void'(q_cyc.pop_front());
            void'(q_cls.pop_front());
            repeat (`FC_CO) void'(q_score.pop_front());
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        reset_n      = 1'b0;
        i_feat_valid = 1'b0;
        i_feat       = '0;
        cyc          = 0;
        errors       = 0;
        checks       = 0;
        rng          = 32'hb2631659;
        $readmemh("stage3_fc1_weight.mem", w_ref);
        $readmemh("stage3_fc1_bias.mem", b_ref);
        apply_reset();
        // still clear right after release
        @(negedge clk);
        checks++;
        if (o_class_valid !== 1'b0 || o_scores !== '0) begin
            errors++;
            $display("[ERROR] %0t: outputs not clear after reset", $time);
        end
        @(posedge clk);
        #1;
        repeat (40) run_frame(FRAME_RAND, MAX_GAP, `FC_IN);
        idle_cycles(2);
        // several frames in flight
        repeat (8) run_frame(FRAME_RAND, 0, `FC_IN);
        idle_cycles(2);
        // bias only, then the two extremes
        run_frame(FRAME_ZERO, 0, `FC_IN);
        run_frame(FRAME_MIN, 0, `FC_IN);
        run_frame(FRAME_MAX, 0, `FC_IN);
        drain_results();
        // partial frame cut by reset must vanish
        run_frame(FRAME_RAND, 0, 7);
        apply_reset();
        run_frame(FRAME_RAND, MAX_GAP, `FC_IN);
        drain_results();
        idle_cycles(4);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog timeout: the expected results did not arrive in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* stage3_fc1_weight.mem */
// one signed 8-bit weight per line, address = feature * 3 + channel
1a
e7
05
c3
7f
80
22
9d
0b
f1
44
bc
3e
06
d2
81
19
6a
f8
2c
a5
57
0e
e0
63
b9
12
d7
4b
08
fe
35
c9
70
88
2f
9a
14
61
e3
5c
07
b0
76
cd
01
ff
3b

/* stage3_fc1_bias.mem */
// one signed 16-bit bias per line, channels 0 to 2
fff0
0040
0040

/* verilog.f */
+incdir+include
rtl/fc_pkg.sv
rtl/fc_mac_array.sv
rtl/fc_bias_core.sv
rtl/fc_argmax.sv
rtl/fc_stage3_top.sv
testbench/tb_fc_stage3.sv

/* run.sh */
#!/bin/sh
# build and run the stage 3 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_fc_stage3 -Mdir obj_dir

out=$(./obj_dir/Vtb_fc_stage3)
echo "$out"

# fails the script when the pass line is missing
echo "$out" | grep -q "^Simulation passed$"
